// ==== design/fe_pkg.sv ====
`default_nettype none

package fe_pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int unsigned XLEN  = 32;
    localparam int unsigned WB_DW = 2 * XLEN;

    //////////////////////////////////////////////////////////////////////
    // fetch side
    //////////////////////////////////////////////////////////////////////

    // one 64-bit bus beat, low word sits at the aligned address
    typedef struct packed {
        logic [XLEN-1:0] hi;
        logic [XLEN-1:0] lo;
    } wb_word_t;

    // valid 2'b11 both slots, 2'b10 slot 0 only, 2'b00 none
    typedef struct packed {
        logic [1:0]      valid;
        logic [XLEN-1:0] pc0;
        logic [XLEN-1:0] inst0;
        logic [XLEN-1:0] pc1;
        logic [XLEN-1:0] inst1;
    } inst_pair_t;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
    } fq_entry_t;

    //////////////////////////////////////////////////////////////////////
    // decode side
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [2:0] {
        OP_ALU,
        OP_ALU_IMM,
        OP_LOAD,
        OP_STORE,
        OP_BRANCH,
        OP_JUMP,
        OP_SYSTEM,
        OP_ILLEGAL
    } op_class_e;

    typedef struct packed {
        logic [XLEN-1:0] pc;
        logic [XLEN-1:0] inst;
        op_class_e       cls;
        logic [4:0]      rd;
        logic [4:0]      rs1;
        logic [4:0]      rs2;
    } dec_slot_t;

    // rv32i major opcodes
    function automatic op_class_e op_classify(input logic [6:0] opcode);
        op_class_e cls;
        case (opcode)
            7'b0110011: cls = OP_ALU;
            7'b0010011: cls = OP_ALU_IMM;
            7'b0110111: cls = OP_ALU_IMM;  // lui
            7'b0010111: cls = OP_ALU_IMM;  // auipc
            7'b0000011: cls = OP_LOAD;
            7'b0100011: cls = OP_STORE;
            7'b1100011: cls = OP_BRANCH;
            7'b1101111: cls = OP_JUMP;
            7'b1100111: cls = OP_JUMP;
            7'b1110011: cls = OP_SYSTEM;
            7'b0001111: cls = OP_SYSTEM;   // fence
            default:    cls = OP_ILLEGAL;
        endcase
        return cls;
    endfunction

endpackage

`default_nettype wire

// ==== design/fetch_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_unit #(
    parameter int unsigned              QUEUE_DEPTH = 16,
    parameter logic [fe_pkg::XLEN-1:0]  RESET_PC    = 32'h0000_1000
) (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    input  wire logic                       i_redirect,
    input  wire logic [fe_pkg::XLEN-1:0]    i_redirect_pc,
    input  wire logic                       i_near_full,
    output logic                            o_wb_cyc,
    output logic                            o_wb_stb,
    output logic [fe_pkg::XLEN-1:0]         o_wb_adr,
    input  wire logic [fe_pkg::WB_DW-1:0]   i_wb_dat,
    input  wire logic                       i_wb_ack,
    output fe_pkg::inst_pair_t              o_push
);

    import fe_pkg::*;

    logic [XLEN-1:0] pc_q;
    logic [XLEN-1:0] pc_next;
    logic [XLEN-1:0] pc_seq;
    logic [XLEN-1:0] adr_q;
    logic            cyc_q;
    logic            drop_q;
    logic            done;
    logic            take;
    logic            start;
    wb_word_t        bus_word;

    // a read started below near-full must always fit, which needs a few
    // entries of slack in the queue
    initial begin
        assert (QUEUE_DEPTH >= 8 && (QUEUE_DEPTH & (QUEUE_DEPTH - 1)) == 0)
            else $fatal(1, "fetch_unit: QUEUE_DEPTH must be a power of two, 8 or more");
    end

    //////////////////////////////////////////////////////////////////////
    // pc and bus control
    //////////////////////////////////////////////////////////////////////

    assign bus_word = wb_word_t'(i_wb_dat);
    assign done     = cyc_q & i_wb_ack;
    // response of a read overtaken by a redirect is thrown away
    assign take     = done & ~drop_q & ~i_redirect;
    assign pc_seq   = {pc_q[XLEN-1:3] + 1'b1, 3'b000};

    always_comb begin
        if (i_redirect) begin
            pc_next = i_redirect_pc;
        end else if (take) begin
            pc_next = pc_seq;
        end else begin
            pc_next = pc_q;
        end
    end

    // bus free after this edge, queue flushed on redirect so pressure is moot
    assign start = (~cyc_q | done) & (~i_near_full | i_redirect);

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            cyc_q  <= 1'b0;
            drop_q <= 1'b0;
            pc_q   <= RESET_PC;
        end else begin
            pc_q <= pc_next;
            if (start) begin
                cyc_q <= 1'b1;
            end else if (done) begin
                cyc_q <= 1'b0;
            end
            if (i_redirect) begin
                drop_q <= cyc_q & ~i_wb_ack;
            end else if (done) begin
                drop_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            adr_q <= {pc_next[XLEN-1:3], 3'b000};
        end
    end

    assign o_wb_cyc = cyc_q;
    assign o_wb_stb = cyc_q;
    assign o_wb_adr = adr_q;

    //////////////////////////////////////////////////////////////////////
    // pair toward the queue
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        o_push = '0;
        if (take) begin
            if (pc_q[2]) begin
                // entered mid pair, only the upper word belongs to the path
                o_push.valid = 2'b10;
                o_push.pc0   = {pc_q[XLEN-1:3], 3'b100};
                o_push.inst0 = bus_word.hi;
            end else begin
                o_push.valid = 2'b11;
                o_push.pc0   = {pc_q[XLEN-1:3], 3'b000};
                o_push.inst0 = bus_word.lo;
                o_push.pc1   = {pc_q[XLEN-1:3], 3'b100};
                o_push.inst1 = bus_word.hi;
            end
        end
    end

    // classic wishbone, request held until the slave acks
    a_adr_stable: assert property (
        @(posedge clk) disable iff (!rstn)
        (o_wb_stb && !i_wb_ack) |=> (o_wb_stb && $stable(o_wb_adr))
    ) else $error("fetch_unit: wishbone request changed before ack");

endmodule

`default_nettype wire

// ==== design/fetch_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module fetch_queue #(
    parameter int unsigned QUEUE_DEPTH = 16
) (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   i_flush,
    input  wire fe_pkg::inst_pair_t     i_push,
    input  wire logic                   i_pop_ready,
    output logic [1:0]                  o_head_valid,
    output fe_pkg::fq_entry_t           o_head0,
    output fe_pkg::fq_entry_t           o_head1,
    output logic                        o_near_full
);

    import fe_pkg::*;

    localparam int unsigned PTR_W = $clog2(QUEUE_DEPTH);
    localparam int unsigned CNT_W = PTR_W + 1;

    // entries at or above this level stop new fetches
    localparam logic [CNT_W-1:0] NEAR_FULL_LVL = CNT_W'(QUEUE_DEPTH - 4);
    localparam logic [CNT_W-1:0] DEPTH_LVL     = CNT_W'(QUEUE_DEPTH);

    fq_entry_t          mem_q [QUEUE_DEPTH];

    logic [PTR_W-1:0]   rd_ptr_q;
    logic [PTR_W-1:0]   wr_ptr_q;
    logic [PTR_W-1:0]   rd_ptr_p1;
    logic [PTR_W-1:0]   wr_ptr_p1;
    logic [CNT_W-1:0]   count_q;
    logic [CNT_W-1:0]   count_next;
    logic [1:0]         push_n;
    logic [1:0]         pop_n;
    logic               near_full_q;

    //////////////////////////////////////////////////////////////////////
    // push and pop sizes
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        case (i_push.valid)
            2'b11:   push_n = 2'd2;
            2'b10:   push_n = 2'd1;
            default: push_n = 2'd0;
        endcase
    end

    // head valid straight from the level, never 2'b01
    always_comb begin
        if (count_q >= CNT_W'(2)) begin
            o_head_valid = 2'b11;
        end else if (count_q == CNT_W'(1)) begin
            o_head_valid = 2'b10;
        end else begin
            o_head_valid = 2'b00;
        end
    end

    always_comb begin
        if (!i_pop_ready) begin
            pop_n = 2'd0;
        end else begin
            case (o_head_valid)
                2'b11:   pop_n = 2'd2;
                2'b10:   pop_n = 2'd1;
                default: pop_n = 2'd0;
            endcase
        end
    end

    assign count_next = count_q + CNT_W'(push_n) - CNT_W'(pop_n);

    // pointers wrap on their own since the depth is a power of two
    assign rd_ptr_p1 = rd_ptr_q + PTR_W'(1);
    assign wr_ptr_p1 = wr_ptr_q + PTR_W'(1);

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!i_flush && push_n != 2'd0) begin
            mem_q[wr_ptr_q] <= '{pc: i_push.pc0, inst: i_push.inst0};
        end
        if (!i_flush && push_n == 2'd2) begin
            mem_q[wr_ptr_p1] <= '{pc: i_push.pc1, inst: i_push.inst1};
        end
    end

    // first word fall through, always read from the array
    assign o_head0 = mem_q[rd_ptr_q];
    assign o_head1 = mem_q[rd_ptr_p1];

    //////////////////////////////////////////////////////////////////////
    // pointers and level
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            rd_ptr_q    <= '0;
            wr_ptr_q    <= '0;
            count_q     <= '0;
            near_full_q <= 1'b0;
        end else if (i_flush) begin
            rd_ptr_q    <= '0;
            wr_ptr_q    <= '0;
            count_q     <= '0;
            near_full_q <= 1'b0;
        end else begin
            wr_ptr_q    <= wr_ptr_q + PTR_W'(push_n);
            rd_ptr_q    <= rd_ptr_q + PTR_W'(pop_n);
            count_q     <= count_next;
            near_full_q <= (count_next >= NEAR_FULL_LVL);
        end
    end

    assign o_near_full = near_full_q;

    // fetch must hold off early enough that every pair finds room
    a_no_overflow: assert property (
        @(posedge clk) disable iff (!rstn)
        !i_flush |-> (CNT_W'(push_n) <= DEPTH_LVL - count_q)
    ) else $error("fetch_queue: push of %0d with %0d entries held", push_n, count_q);

endmodule

`default_nettype wire

// ==== design/decode_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_stage (
    input  wire logic                   clk,
    input  wire logic                   rstn,
    input  wire logic                   i_flush,
    input  wire logic                   i_issue_stall,
    input  wire logic [1:0]             i_head_valid,
    input  wire fe_pkg::fq_entry_t      i_head0,
    input  wire fe_pkg::fq_entry_t      i_head1,
    output logic                        o_pop_ready,
    output logic [1:0]                  o_issue_valid,
    output fe_pkg::dec_slot_t           o_slot0,
    output fe_pkg::dec_slot_t           o_slot1
);

    import fe_pkg::*;

    dec_slot_t dec0;
    dec_slot_t dec1;

    // class plus register fields, stores and branches write no rd
    function automatic dec_slot_t decode_entry(input fq_entry_t e);
        dec_slot_t d;
        d.pc   = e.pc;
        d.inst = e.inst;
        d.cls  = op_classify(e.inst[6:0]);
        d.rs1  = e.inst[19:15];
        d.rs2  = e.inst[24:20];
        if (d.cls == OP_STORE || d.cls == OP_BRANCH) begin
            d.rd = 5'd0;
        end else begin
            d.rd = e.inst[11:7];
        end
        return d;
    endfunction

    assign dec0 = decode_entry(i_head0);
    assign dec1 = decode_entry(i_head1);

    // register drains every cycle issue is not stalled
    assign o_pop_ready = ~i_issue_stall;

    //////////////////////////////////////////////////////////////////////
    // id1 register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            o_issue_valid <= 2'b00;
        end else if (i_flush) begin
            o_issue_valid <= 2'b00;
        end else if (!i_issue_stall) begin
            o_issue_valid <= i_head_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (!i_issue_stall) begin
            o_slot0 <= dec0;
            o_slot1 <= dec1;
        end
    end

    // slot 1 alone would break program order at issue
    a_no_lone_slot1: assert property (
        @(posedge clk) disable iff (!rstn)
        o_issue_valid != 2'b01
    ) else $error("decode_stage: slot 1 valid without slot 0");

endmodule

`default_nettype wire

// ==== design/frontend_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module frontend_top #(
    parameter int unsigned              QUEUE_DEPTH = 16,
    parameter logic [fe_pkg::XLEN-1:0]  RESET_PC    = 32'h0000_1000
) (
    input  wire logic                       clk,
    input  wire logic                       rstn,
    // instruction memory, read only
    output logic                            o_wb_cyc,
    output logic                            o_wb_stb,
    output logic [fe_pkg::XLEN-1:0]         o_wb_adr,
    input  wire logic [fe_pkg::WB_DW-1:0]   i_wb_dat,
    input  wire logic                       i_wb_ack,
    // back end
    input  wire logic                       i_redirect,
    input  wire logic [fe_pkg::XLEN-1:0]    i_redirect_pc,
    input  wire logic                       i_issue_stall,
    output logic [1:0]                      o_issue_valid,
    output fe_pkg::dec_slot_t               o_slot0,
    output fe_pkg::dec_slot_t               o_slot1
);

    import fe_pkg::*;

    inst_pair_t push;
    logic       near_full;
    logic [1:0] head_valid;
    fq_entry_t  head0;
    fq_entry_t  head1;
    logic       pop_ready;

    //////////////////////////////////////////////////////////////////////
    // fetch, queue, id1
    //////////////////////////////////////////////////////////////////////

    fetch_unit #(
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .RESET_PC      (RESET_PC)
    ) fetch_unit_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_redirect    (i_redirect),
        .i_redirect_pc (i_redirect_pc),
        .i_near_full   (near_full),
        .o_wb_cyc      (o_wb_cyc),
        .o_wb_stb      (o_wb_stb),
        .o_wb_adr      (o_wb_adr),
        .i_wb_dat      (i_wb_dat),
        .i_wb_ack      (i_wb_ack),
        .o_push        (push)
    );

    // redirect empties both the queue and the id1 register
    fetch_queue #(
        .QUEUE_DEPTH   (QUEUE_DEPTH)
    ) fetch_queue_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_flush       (i_redirect),
        .i_push        (push),
        .i_pop_ready   (pop_ready),
        .o_head_valid  (head_valid),
        .o_head0       (head0),
        .o_head1       (head1),
        .o_near_full   (near_full)
    );

    decode_stage decode_stage_inst (
        .clk           (clk),
        .rstn          (rstn),
        .i_flush       (i_redirect),
        .i_issue_stall (i_issue_stall),
        .i_head_valid  (head_valid),
        .i_head0       (head0),
        .i_head1       (head1),
        .o_pop_ready   (pop_ready),
        .o_issue_valid (o_issue_valid),
        .o_slot0       (o_slot0),
        .o_slot1       (o_slot1)
    );

endmodule

`default_nettype wire

// ==== test/tb_frontend.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_frontend #(
    parameter logic [31:0] SEED = 32'h9abe_b218
);

    import fe_pkg::*;

    localparam int unsigned QUEUE_DEPTH = 16;
    localparam logic [31:0] RESET_PC    = 32'h0000_1000;
    localparam int          N_ROWS      = 7;

    // memory content indexed by word address mod 8
    localparam logic [6:0] OPC_TAB [8] = '{7'b0110011, 7'b0010011, 7'b0000011, 7'b0100011,
                                           7'b1100011, 7'b1101111, 7'b1110011, 7'b0001011};
    localparam op_class_e  CLS_TAB [8] = '{OP_ALU, OP_ALU_IMM, OP_LOAD, OP_STORE,
                                           OP_BRANCH, OP_JUMP, OP_SYSTEM, OP_ILLEGAL};

    typedef struct packed {
        logic [15:0] n_insts;
        logic [15:0] stall_len;
        logic        hold;
        logic        redir;
        logic [31:0] redir_pc;
    } row_t;

    // instructions to collect, stall cycles, continuous stall, redirect, target
    localparam row_t ROWS [N_ROWS] = '{
        '{16'd40, 16'd0,  1'b0, 1'b0, 32'h0000_0000},
        '{16'd60, 16'd40, 1'b0, 1'b0, 32'h0000_0000},
        '{16'd20, 16'd0,  1'b0, 1'b1, 32'h0000_2000},
        '{16'd20, 16'd0,  1'b0, 1'b1, 32'h0000_3a44},
        '{16'd30, 16'd60, 1'b1, 1'b0, 32'h0000_0000},
        '{16'd40, 16'd30, 1'b0, 1'b1, 32'h0001_0f0c},
        '{16'd16, 16'd0,  1'b0, 1'b1, 32'h0000_2004}
    };

    logic        clk;
    logic        rstn        = 1'b0;
    logic        wb_cyc;
    logic        wb_stb;
    logic [31:0] wb_adr;
    logic [63:0] wb_dat      = '0;
    logic        wb_ack      = 1'b0;
    logic        redirect    = 1'b0;
    logic [31:0] redirect_pc = '0;
    logic        issue_stall = 1'b0;
    logic [1:0]  issue_valid;
    dec_slot_t   slot0;
    dec_slot_t   slot1;

    integer      seed        = SEED;
    logic [1:0]  wait_cnt    = 2'd0;
    logic [31:0] exp_pc      = RESET_PC;
    int unsigned issued_cnt  = 0;
    int unsigned cycles      = 0;
    int unsigned limit;
    // registered view of the previous edge
    logic        stall_d     = 1'b0;
    logic        redir_d     = 1'b0;
    logic [1:0]  valid_d     = 2'b00;
    dec_slot_t   slot0_d;
    dec_slot_t   slot1_d;
    // continuous stall bookkeeping
    logic        in_hold     = 1'b0;
    int          hold_cycles = 0;
    int          hold_acks   = 0;
    int          last_stb    = -1;

    frontend_top #(
        .QUEUE_DEPTH   (QUEUE_DEPTH),
        .RESET_PC      (RESET_PC)
    ) frontend_top_inst (
        .clk           (clk),
        .rstn          (rstn),
        .o_wb_cyc      (wb_cyc),
        .o_wb_stb      (wb_stb),
        .o_wb_adr      (wb_adr),
        .i_wb_dat      (wb_dat),
        .i_wb_ack      (wb_ack),
        .i_redirect    (redirect),
        .i_redirect_pc (redirect_pc),
        .i_issue_stall (issue_stall),
        .o_issue_valid (issue_valid),
        .o_slot0       (slot0),
        .o_slot1       (slot1)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic check_eq(input logic [127:0] got, input logic [127:0] exp,
                            input string what);
        if (got !== exp) begin
            $display("ERR %0t ns %s: got %0h expected %0h", $time, what, got, exp);
            $display("Checks failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] mem_word(input logic [31:0] a);
        logic [31:0] h;
        h = a ^ {a[15:0], a[31:16]} ^ (a >> 5) ^ 32'h5a3c_9e11;
        return {h[31:7], OPC_TAB[a[4:2]]};
    endfunction

    //////////////////////////////////////////////////////////////////////
    // wishbone slave with 0 to 3 wait states
    //////////////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        if (wb_ack) begin
            wb_ack <= 1'b0;
        end else if (wb_cyc && wb_stb) begin
            if (wait_cnt == 2'd0) begin
                wb_ack   <= 1'b1;
                wb_dat   <= {mem_word(wb_adr + 32'd4), mem_word(wb_adr)};
                wait_cnt <= 2'($random(seed));
            end else begin
                wait_cnt <= wait_cnt - 2'd1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // issue side monitor and reference
    //////////////////////////////////////////////////////////////////////

    // one issued slot against the next expected pc
    task automatic expect_slot(input dec_slot_t s, input string which);
        logic [31:0] w;
        op_class_e   cls;
        w   = mem_word(exp_pc);
        cls = CLS_TAB[exp_pc[4:2]];
        check_eq(s.pc, exp_pc, {which, " pc"});
        check_eq(s.inst, w, {which, " instruction"});
        check_eq(s.cls, cls, {which, " class"});
        check_eq(s.rd, (cls == OP_STORE || cls == OP_BRANCH) ? 5'd0 : w[11:7], {which, " rd"});
        check_eq(s.rs1, w[19:15], {which, " rs1"});
        check_eq(s.rs2, w[24:20], {which, " rs2"});
        exp_pc = exp_pc + 32'd4;
        issued_cnt++;
    endtask

    always @(posedge clk) begin
        if (rstn) begin
            check_eq(issue_valid == 2'b01, 1'b0, "slot 1 valid without slot 0");
            if (redir_d) begin
                check_eq(issue_valid, 2'b00, "issue valid right after redirect");
            end
            if (stall_d && !redir_d) begin
                check_eq(issue_valid, valid_d, "issue valid held under stall");
                check_eq(slot0, slot0_d, "slot 0 held under stall");
                check_eq(slot1, slot1_d, "slot 1 held under stall");
            end
            // slots shown at a redirect edge belong to the old path
            if (redirect) begin
                exp_pc = redirect_pc;
            end else if (!issue_stall) begin
                if (issue_valid[1]) begin
                    expect_slot(slot0, "slot 0");
                end
                if (issue_valid[0]) begin
                    expect_slot(slot1, "slot 1");
                end
            end
            if (in_hold) begin
                if (wb_cyc && wb_ack) begin
                    hold_acks++;
                end
                if (wb_stb) begin
                    last_stb = hold_cycles;
                end
                hold_cycles++;
            end
            stall_d = issue_stall;
            redir_d = redirect;
            valid_d = issue_valid;
            slot0_d = slot0;
            slot1_d = slot1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Checks failed");
            $fatal(1, "timeout");
        end
    end

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////

    task automatic run_row(input row_t row);
        int unsigned target;
        if (row.redir) begin
            @(posedge clk);
            redirect    <= 1'b1;
            redirect_pc <= row.redir_pc;
            @(posedge clk);
            redirect    <= 1'b0;
        end
        if (row.hold) begin
            hold_cycles = 0;
            hold_acks   = 0;
            last_stb    = -1;
            @(posedge clk);
            issue_stall <= 1'b1;
            in_hold     <= 1'b1;
            repeat (row.stall_len) @(posedge clk);
            issue_stall <= 1'b0;
            in_hold     <= 1'b0;
            @(posedge clk);
            check_eq(hold_acks <= QUEUE_DEPTH / 2, 1'b1, "reads acked during full stall");
            check_eq(last_stb + 16 < hold_cycles, 1'b1, "bus idle at end of full stall");
        end else begin
            repeat (row.stall_len) begin
                @(posedge clk);
                issue_stall <= 1'($random(seed));
            end
            @(posedge clk);
            issue_stall <= 1'b0;
        end
        target = issued_cnt + 32'(row.n_insts);
        wait (issued_cnt >= target);
        @(posedge clk);
    endtask

    initial begin
        limit = 500;
        for (int r = 0; r < N_ROWS; r++) begin
            limit = limit + 64 * 32'(ROWS[r].n_insts);
        end
        repeat (3) @(posedge clk);
        rstn <= 1'b1;
        for (int r = 0; r < N_ROWS; r++) begin
            run_row(ROWS[r]);
        end
        repeat (4) @(posedge clk);
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== list.f ====
design/fe_pkg.sv
design/fetch_unit.sv
design/fetch_queue.sv
design/decode_stage.sv
design/frontend_top.sv
test/tb_frontend.sv

// ==== Makefile ====
# Verilator build and run for the instruction front end

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -Wno-fatal
TOP       ?= tb_frontend
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
SEED      ?= 32\'h9abe_b218
FLIST     ?= list.f

SRCS := $(filter-out +incdir+%,$(shell cat $(FLIST)))
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) -GSEED=$(SEED) -Mdir $(OBJ_DIR)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "Checks failed" $(LOG); then echo "simulation FAILED"; exit 1; fi
	@if ! grep -q "All checks passed" $(LOG); then echo "simulation ended early"; exit 1; fi
	@echo "simulation passed"

clean:
	rm -rf $(OBJ_DIR) $(LOG)
